// ==== design/csr_index_pkg.sv ====
package csr_index_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int index_w = 32;
    localparam int shift_w = 5;
    localparam int route_w = 8;

    // ------------------------------
    // Request FIFO sizing
    // ------------------------------
    localparam int fifo_depth = 16;

    // Fill level where generation is asked to pause
    localparam int prog_thresh = 8;

    // Read and write pointer width
    localparam int fifo_addr_w = $clog2(fifo_depth);

    // Occupancy needs one extra bit to reach a full count
    localparam int fifo_count_w = $clog2(fifo_depth + 1);

    typedef logic [index_w-1:0] index_t;

    // ------------------------------
    // Configuration of one neighbor walk
    // ------------------------------
    typedef struct packed {
        logic [index_w-1:0] array_pointer;
        index_t             index_start;
        index_t             index_end;
        index_t             stride;
        logic               shift_left;
        logic [shift_w-1:0] shift_amount;
        logic [route_w-1:0] route;
    } csr_index_config_t;

endpackage

// ==== design/mem_packet_pkg.sv ====
package mem_packet_pkg;

    import csr_index_pkg::*;

    // ------------------------------
    // Address format
    // ------------------------------
    localparam int addr_w = 32;

    // Array base plus scaled neighbor offset
    typedef struct packed {
        logic [addr_w-1:0] base;
        logic [addr_w-1:0] offset;
    } mem_address_t;

    // ------------------------------
    // Memory request packet
    // ------------------------------
    // Valid sits in the top bit so the payload is the low slice
    typedef struct packed {
        logic               valid;
        logic [route_w-1:0] route;
        mem_address_t       address;
        index_t             data;
    } mem_request_t;

    // Stored width in the request FIFO
    localparam int mem_payload_w = $bits(mem_request_t) - 1;

endpackage

// ==== design/csr_index_control.sv ====
module csr_index_control
    import csr_index_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  csr_index_config_t config_in,
    input  logic              config_valid,
    output logic              config_ready,
    input  index_t            index,
    input  logic              prog_full,
    output logic              counter_load,
    output logic              counter_enable,
    output logic              gen_valid,
    output csr_index_config_t active_config,
    output logic              done
);

    typedef enum logic [2:0] {
        state_idle,
        state_start,
        state_busy,
        state_pause,
        state_done
    } state_t;

    state_t state;
    state_t next_state;

    logic prog_full_q;
    logic accept;
    logic index_in_range;

    assign accept         = config_valid & config_ready;
    assign index_in_range = index < active_config.index_end;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (accept) begin
                    next_state = state_start;
                end
            end
            // Counter loads the start index here
            state_start: begin
                next_state = state_busy;
            end
            state_busy: begin
                if (!index_in_range) begin
                    next_state = state_done;
                end else if (prog_full_q) begin
                    next_state = state_pause;
                end
            end
            state_pause: begin
                if (!prog_full_q) begin
                    next_state = state_busy;
                end
            end
            state_done: begin
                next_state = state_idle;
            end
            default: begin
                next_state = state_idle;
            end
        endcase
    end

    // ------------------------------
    // State and control registers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state        <= state_idle;
            config_ready <= 1'b0;
            prog_full_q  <= 1'b0;
        end else begin
            state        <= next_state;
            config_ready <= (next_state == state_idle);
            // FIFO pressure is seen one cycle late
            prog_full_q  <= prog_full;
        end
    end

    // Held for the whole walk
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            active_config <= config_in;
        end
    end

    // ------------------------------
    // Outputs to the datapath
    // ------------------------------
    assign counter_load = (state == state_start);

    // One index per cycle while below end and the FIFO has room
    assign gen_valid = (state == state_busy) & index_in_range & ~prog_full_q;

    // Counter only advances past an index that was issued
    assign counter_enable = gen_valid;

    assign done = (state == state_done);

    // Walk begins at the configured start index
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        counter_load |=> (index == active_config.index_start));

endmodule

// ==== design/index_counter.sv ====
module index_counter
    import csr_index_pkg::*;
(
    input  logic   ap_clk,
    input  logic   areset_generator,
    input  logic   load,
    input  logic   enable,
    input  index_t load_value,
    input  index_t stride,
    output index_t index
);

    // ------------------------------
    // Stride counter
    // ------------------------------
    // Load wins over enable
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            index <= '0;
        end else if (load) begin
            index <= load_value;
        end else if (enable) begin
            index <= index + stride;
        end
    end

    // A zero stride would never reach the end index
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        load |-> (stride != '0));

endmodule

// ==== design/request_address_gen.sv ====
module request_address_gen
    import csr_index_pkg::*;
    import mem_packet_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  index_t            index,
    input  logic              gen_valid,
    input  csr_index_config_t active_config,
    output mem_request_t      request
);

    logic [addr_w-1:0] offset;

    // ------------------------------
    // Offset scaling
    // ------------------------------
    // Left shift turns an index into a byte offset for wide elements
    always_comb begin
        if (active_config.shift_left) begin
            offset = index << active_config.shift_amount;
        end else begin
            offset = index >> active_config.shift_amount;
        end
    end

    // ------------------------------
    // Packet register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request.valid <= 1'b0;
        end else begin
            request.valid <= gen_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        request.route          <= active_config.route;
        request.address.base   <= active_config.array_pointer;
        request.address.offset <= offset;
        // Neighbor id travels with the request
        request.data           <= index;
    end

endmodule

// ==== design/request_fifo.sv ====
module request_fifo
    import csr_index_pkg::*;
    import mem_packet_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_generator,
    input  mem_request_t write,
    input  logic         request_ready,
    output logic         prog_full,
    output mem_request_t request_out
);

    logic [mem_payload_w-1:0] storage [fifo_depth];

    logic [fifo_addr_w-1:0]  wr_ptr;
    logic [fifo_addr_w-1:0]  rd_ptr;
    logic [fifo_count_w-1:0] count;

    logic empty;
    logic full;
    logic push;
    logic pop;

    assign empty = (count == '0);
    assign full  = (count == fifo_count_w'(fifo_depth));
    assign push  = write.valid & ~full;
    assign pop   = ~empty & request_ready;

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    // Depth is a power of two so pointers wrap on their own
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            storage[wr_ptr] <= write[mem_payload_w-1:0];
        end
    end

    // Show-ahead read with valid rebuilt from occupancy
    assign request_out = mem_request_t'({~empty, storage[rd_ptr]});

    assign prog_full = (count >= fifo_count_w'(prog_thresh));

    // Control must pause early enough to keep headroom
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        write.valid |-> !full);

endmodule

// ==== design/csr_index_generator.sv ====
module csr_index_generator
    import csr_index_pkg::*;
    import mem_packet_pkg::*;
(
    input  logic              ap_clk,
    input  logic              areset_generator,
    input  csr_index_config_t config_in,
    input  logic              config_valid,
    output logic              config_ready,
    output mem_request_t      request_out,
    input  logic              request_ready,
    output logic              done
);

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic              counter_load;
    logic              counter_enable;
    logic              gen_valid;
    logic              prog_full;
    index_t            index;
    csr_index_config_t active_config;
    mem_request_t      fifo_write;

    csr_index_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_in        (config_in),
        .config_valid     (config_valid),
        .config_ready     (config_ready),
        .index            (index),
        .prog_full        (prog_full),
        .counter_load     (counter_load),
        .counter_enable   (counter_enable),
        .gen_valid        (gen_valid),
        .active_config    (active_config),
        .done             (done)
    );

    // Start and stride come from the held configuration
    index_counter u_counter (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .load             (counter_load),
        .enable           (counter_enable),
        .load_value       (active_config.index_start),
        .stride           (active_config.stride),
        .index            (index)
    );

    request_address_gen u_address_gen (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .index            (index),
        .gen_valid        (gen_valid),
        .active_config    (active_config),
        .request          (fifo_write)
    );

    request_fifo u_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .write            (fifo_write),
        .request_ready    (request_ready),
        .prog_full        (prog_full),
        .request_out      (request_out)
    );

endmodule

// ==== tb/csr_index_generator_tb.sv ====
module csr_index_generator_tb
    import csr_index_pkg::*;
    import mem_packet_pkg::*;
();

    localparam int kind_normal = 0;
    localparam int kind_long   = 1;
    localparam int kind_empty  = 2;

    logic              ap_clk;
    logic              areset_generator;
    csr_index_config_t config_in;
    logic              config_valid;
    logic              config_ready;
    mem_request_t      request_out;
    logic              request_ready;
    logic              done;

    logic [31:0]       lfsr_state = 32'h628c;
    logic              ready_random;
    logic              busy;
    int                error_count;
    int                check_count;
    int                packets_seen;
    int                done_count;
    int                total_indices;
    int                limit_cycles;
    csr_index_config_t cfg_q[$];
    mem_request_t      exp_q[$];

    csr_index_generator uut (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_in        (config_in),
        .config_valid     (config_valid),
        .config_ready     (config_ready),
        .request_out      (request_out),
        .request_ready    (request_ready),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Random numbers
    // ------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int nbits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic mem_request_t build_packet(input csr_index_config_t cfg,
                                                  input index_t idx);
        mem_request_t pkt;
        pkt.valid          = 1'b1;
        pkt.route          = cfg.route;
        pkt.address.base   = cfg.array_pointer;
        pkt.address.offset = cfg.shift_left ? (idx << cfg.shift_amount)
                                            : (idx >> cfg.shift_amount);
        pkt.data           = idx;
        return pkt;
    endfunction

    function automatic int count_indices(input csr_index_config_t cfg);
        int n;
        n = 0;
        for (index_t idx = cfg.index_start; idx < cfg.index_end; idx += cfg.stride) begin
            n++;
        end
        return n;
    endfunction

    // Small values keep the walk far from index wrap
    function automatic csr_index_config_t make_config(input logic shift_left, input int kind);
        csr_index_config_t cfg;
        int                len;
        cfg.array_pointer = random_bits(32);
        cfg.index_start   = random_bits(10);
        cfg.stride        = random_bits(3) + 1;
        cfg.shift_left    = shift_left;
        cfg.shift_amount  = random_bits(5);
        cfg.route         = random_bits(8);
        if (kind == kind_empty) begin
            cfg.index_end = cfg.index_start & random_bits(10);
        end else begin
            len = (kind == kind_long) ? 17 + random_bits(5) : 1 + random_bits(3);
            cfg.index_end = cfg.index_start + (len - 1) * cfg.stride + 1
                            + (random_bits(3) % cfg.stride);
        end
        return cfg;
    endfunction

    task automatic compare_values(input logic [127:0] actual, input logic [127:0] expected,
                                  input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s mismatch, got %h expected %h",
                     $time, what, actual, expected);
        end
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(negedge ap_clk) begin : monitor
        index_t       idx;
        mem_request_t expected;
        if (!areset_generator) begin
            if (busy) begin
                compare_values(config_ready, 1'b0, "config_ready during a walk");
            end
            if (request_out.valid && request_ready) begin
                packets_seen++;
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected request at time %0t with no packet left in the model",
                             $time);
                end else begin
                    expected = exp_q.pop_front();
                    compare_values(request_out, expected, "request packet");
                end
            end
            if (done) begin
                compare_values(busy, 1'b1, "done pulse outside a walk");
                busy = 1'b0;
                done_count++;
            end
            if (config_valid && config_ready) begin
                for (idx = config_in.index_start; idx < config_in.index_end;
                     idx += config_in.stride) begin
                    exp_q.push_back(build_packet(config_in, idx));
                end
                busy = 1'b1;
            end
        end
    end

    // Long random low stretches when back-pressure is on
    initial begin : ready_driver
        int stretch;
        request_ready = 1'b1;
        stretch = 0;
        forever begin
            @(posedge ap_clk);
            #1;
            if (!ready_random) begin
                request_ready = 1'b1;
            end else if (stretch == 0) begin
                request_ready = random_bits(1);
                stretch = 4 + random_bits(5);
            end else begin
                stretch--;
            end
        end
    end

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge ap_clk);
        $display("Watchdog: the run timed out after %0d cycles", limit_cycles);
        $display("Testbench failed");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic send_config(input csr_index_config_t cfg);
        int done_before;
        done_before = done_count;
        @(posedge ap_clk);
        #1;
        config_in    = cfg;
        config_valid = 1'b1;
        do @(negedge ap_clk); while (!config_ready);
        @(posedge ap_clk);
        #1;
        config_valid = 1'b0;
        wait (done_count != done_before);
    endtask

    task automatic run_test(input string name, input int n, input logic random_ready);
        int                errors_before;
        int                seen_before;
        int                done_before;
        int                expected;
        csr_index_config_t cfg;
        errors_before = error_count;
        seen_before   = packets_seen;
        done_before   = done_count;
        expected      = 0;
        ready_random  = random_ready;
        for (int i = 0; i < n; i++) begin
            cfg = cfg_q.pop_front();
            expected += count_indices(cfg);
            send_config(cfg);
        end
        while (exp_q.size() != 0) @(posedge ap_clk);
        // Late extra packets would still show up here
        repeat (4) @(posedge ap_clk);
        compare_values(packets_seen - seen_before, expected, {name, " packet count"});
        compare_values(done_count - done_before, n, {name, " done pulses"});
        $display("%s: %0d configs, %0d packets, %0d errors",
                 name, n, expected, error_count - errors_before);
    endtask

    initial begin
        areset_generator = 1'b1;
        config_in        = '0;
        config_valid     = 1'b0;
        ready_random     = 1'b0;
        busy             = 1'b0;
        error_count      = 0;
        check_count      = 0;
        packets_seen     = 0;
        done_count       = 0;
        total_indices    = 0;

        // All walks drawn up front so the watchdog knows the run length
        for (int i = 0; i < 6; i++) cfg_q.push_back(make_config(1'b1, kind_normal));
        for (int i = 0; i < 6; i++) cfg_q.push_back(make_config(1'b0, kind_normal));
        for (int i = 0; i < 4; i++) cfg_q.push_back(make_config(random_bits(1), kind_long));
        for (int i = 0; i < 9; i++) begin
            cfg_q.push_back(make_config(random_bits(1),
                                        (i % 3 == 0) ? kind_empty : kind_normal));
        end
        foreach (cfg_q[i]) total_indices += count_indices(cfg_q[i]);
        limit_cycles = total_indices * 40 + 2000;

        repeat (5) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        @(negedge ap_clk);
        compare_values(request_out.valid, 1'b0, "request valid after reset");
        compare_values(done, 1'b0, "done after reset");
        @(negedge ap_clk);
        compare_values(request_out.valid, 1'b0, "request valid after reset");
        compare_values(done, 1'b0, "done after reset");
        compare_values(config_ready, 1'b1, "config_ready after reset");
        $display("reset: %0d errors", error_count);

        run_test("left shift", 6, 1'b0);
        run_test("right shift", 6, 1'b0);
        run_test("back-pressure", 4, 1'b1);
        run_test("done and ready", 9, 1'b0);

        $display("Closing counts: %0d checks, %0d packets, %0d errors",
                 check_count, packets_seen, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
design/csr_index_pkg.sv
design/mem_packet_pkg.sv
design/csr_index_control.sv
design/index_counter.sv
design/request_address_gen.sv
design/request_fifo.sv
design/csr_index_generator.sv
tb/csr_index_generator_tb.sv
